// File: Makefile
# Verilator build and run for the TI-99/4A memory glue testbench

VERILATOR ?= verilator
TOP       ?= tb_ti_sys_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/ti_sys_pkg.sv
design/xmem_req_if.sv
design/cpu_mem_map.sv
design/host_ctrl_port.sv
design/xmem_arbiter.sv
design/ti_sys_core.sv
test/ti_sys_core_sva.sv
test/tb_ti_sys_core.sv

// File: design/cpu_mem_map.sv
/*
 * CPU side of the memory map. Decodes the CPU address into a region,
 * blocks writes to ROM and cartridge space, keeps the cartridge bank page
 * and turns the CPU rd/wr levels into external memory requests.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_map (
  input  wire logic                                clk,
  input  wire logic                                cpu_reset,
  input  wire logic [ti_sys_pkg::cpu_addr_w-1:0]   cpu_addr_i,
  input  wire logic                                cpu_rd_i,
  input  wire logic                                cpu_wr_i,
  input  wire logic [ti_sys_pkg::data_w-1:0]       cpu_wdata_i,
  output logic      [ti_sys_pkg::data_w-1:0]       cpu_rdata_o,
  output logic                                     cpu_ready_o,
  xmem_req_if.requester                            mem
);

  ti_sys_pkg::region_e              region;
  logic [ti_sys_pkg::page_w-1:0]    cart_page;
  logic                             access_act;
  logic                             needs_mem;
  logic                             xfer;
  logic                             ready_q;
  logic [ti_sys_pkg::data_w-1:0]    rdata_q;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  always_comb begin
    if (cpu_addr_i[15:13] == 3'b000)
      region = ti_sys_pkg::rom;        // 0000..1FFF console ROM
    else if (cpu_addr_i[15:13] == 3'b001)
      region = ti_sys_pkg::ram;        // 2000..3FFF low 8K expansion
    else if (cpu_addr_i[15:13] == 3'b011)
      region = ti_sys_pkg::cart;       // 6000..7FFF banked cartridge
    else if (cpu_addr_i[15:10] == 6'b1000_00)
      region = ti_sys_pkg::scratch;    // 8000..83FF scratchpad
    else if (cpu_addr_i[15:13] == 3'b101 || cpu_addr_i[15:14] == 2'b11)
      region = ti_sys_pkg::ram;        // A000..FFFF high 24K expansion
    else
      region = ti_sys_pkg::unmapped;
  end

  // Reads go out for every mapped region, writes only to RAM
  always_comb begin
    needs_mem = 1'b0;
    if (cpu_rd_i)
      needs_mem = (region != ti_sys_pkg::unmapped);
    else if (cpu_wr_i)
      needs_mem = (region == ti_sys_pkg::ram) || (region == ti_sys_pkg::scratch);
  end

  assign access_act = (cpu_rd_i || cpu_wr_i) && !ready_q;  // Held but not yet answered

  // ------------------------------------------------------------
  // Memory request
  // ------------------------------------------------------------
  assign mem.valid = access_act && needs_mem;
  assign mem.we    = cpu_wr_i;
  assign mem.be    = 2'b11;       // CPU always moves whole words
  assign mem.wdata = cpu_wdata_i;
  assign mem.addr  = (region == ti_sys_pkg::cart) ?
                     {ti_sys_pkg::cart_base, cart_page, cpu_addr_i[12:1]} :
                     {{(ti_sys_pkg::xaddr_w - ti_sys_pkg::cpu_addr_w + 1){1'b0}},
                      cpu_addr_i[ti_sys_pkg::cpu_addr_w-1:1]};

  assign xfer = mem.valid && mem.ready;

  // Sticky ready, dropped only once the CPU releases rd and wr
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      ready_q <= 1'b0;
    end else if (!cpu_rd_i && !cpu_wr_i) begin
      ready_q <= 1'b0;
    end else if (xfer || (access_act && !needs_mem)) begin
      ready_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer)
      rdata_q <= mem.rdata;
    else if (access_act && !needs_mem)
      rdata_q <= '0;              // Unmapped reads see zero
  end

  // Extended BASIC banking, the page comes from the address of a cart write
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      cart_page <= '0;
    end else if (access_act && cpu_wr_i && region == ti_sys_pkg::cart) begin
      cart_page <= cpu_addr_i[8:1];
    end
  end

  assign cpu_ready_o = ready_q;
  assign cpu_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/host_ctrl_port.sv
/*
 * Host loader port. Address bit 24 picks control space (keyboard rows and
 * the CPU reset-control byte) or memory space (byte access to external memory).
 * Every host request ends with a one-cycle ack.
 */
`timescale 1ns/1ps
`default_nettype none

module host_ctrl_port (
  input  wire logic                                 clk,
  input  wire logic                                 cpu_reset,
  input  wire logic [ti_sys_pkg::host_addr_w-1:0]   host_addr_i,
  input  wire logic                                 host_read_i,
  input  wire logic                                 host_write_i,
  input  wire logic [7:0]                           host_wdata_i,
  output logic      [7:0]                           host_rdata_o,
  output logic                                      host_ack_o,
  input  wire logic [2:0]                           key_row_sel_i,
  output logic      [7:0]                           key_line_o,
  output logic                                      cpu_reset_req_o,
  xmem_req_if.requester                             mem
);

  ti_sys_pkg::host_addr_u  haddr;
  logic [7:0]              key_rows [ti_sys_pkg::kbd_rows];
  logic [7:0]              reset_ctrl;
  logic                    host_req;
  logic                    is_ctrl;
  logic                    ctrl_op;
  logic                    xfer;
  logic                    ack_q;
  logic [7:0]              ctrl_rdata;
  logic [7:0]              mem_rbyte;
  logic [7:0]              rdata_q;

  assign haddr    = host_addr_i;
  assign host_req = host_read_i || host_write_i;
  assign is_ctrl  = haddr.ctrl_view.space;
  assign ctrl_op  = host_req && is_ctrl && !ack_q;   // ack_q masks the held request

  // ------------------------------------------------------------
  // Memory space
  // ------------------------------------------------------------
  assign mem.valid = host_req && !is_ctrl && !ack_q;
  assign mem.addr  = haddr.mem_view.word;
  assign mem.we    = host_write_i;
  assign mem.be    = haddr.mem_view.lane ? 2'b01 : 2'b10;
  assign mem.wdata = {host_wdata_i, host_wdata_i};  // Same byte on both halves

  assign xfer      = mem.valid && mem.ready;
  assign mem_rbyte = haddr.mem_view.lane ? mem.rdata[7:0] : mem.rdata[15:8];

  // ------------------------------------------------------------
  // Control space
  // ------------------------------------------------------------
  always_comb begin
    case (haddr.ctrl_view.group)
      2'd0:    ctrl_rdata = key_rows[haddr.ctrl_view.row];
      2'd1:    ctrl_rdata = reset_ctrl;
      default: ctrl_rdata = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      ack_q      <= 1'b0;
      reset_ctrl <= ti_sys_pkg::reset_ctrl_init;
      for (int i = 0; i < ti_sys_pkg::kbd_rows; i++) begin
        key_rows[i] <= 8'hff;    // All keys up
      end
    end else begin
      ack_q <= ctrl_op || xfer;
      if (ctrl_op && host_write_i) begin
        case (haddr.ctrl_view.group)
          2'd0:    key_rows[haddr.ctrl_view.row] <= host_wdata_i;
          2'd1:    reset_ctrl <= host_wdata_i;
          default: ;               // Unused groups just ack
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_op)
      rdata_q <= ctrl_rdata;
    else if (xfer)
      rdata_q <= mem_rbyte;
  end

  assign host_ack_o      = ack_q;
  assign host_rdata_o    = rdata_q;
  assign key_line_o      = key_rows[key_row_sel_i];
  assign cpu_reset_req_o = !reset_ctrl[0];  // Bit 0 low holds the CPU in reset

endmodule

`default_nettype wire

// File: design/ti_sys_core.sv
/*
 * Top level of the TI-99/4A memory glue. Connects the CPU memory map and
 * the host loader port to one external memory port through the arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module ti_sys_core (
  input  wire logic                                 clk,
  input  wire logic                                 cpu_reset,
  // CPU bus
  input  wire logic [ti_sys_pkg::cpu_addr_w-1:0]    cpu_addr_i,
  input  wire logic                                 cpu_rd_i,
  input  wire logic                                 cpu_wr_i,
  input  wire logic [ti_sys_pkg::data_w-1:0]        cpu_wdata_i,
  output logic      [ti_sys_pkg::data_w-1:0]        cpu_rdata_o,
  output logic                                      cpu_ready_o,
  // Host loader bus
  input  wire logic [ti_sys_pkg::host_addr_w-1:0]   host_addr_i,
  input  wire logic                                 host_read_i,
  input  wire logic                                 host_write_i,
  input  wire logic [7:0]                           host_wdata_i,
  output logic      [7:0]                           host_rdata_o,
  output logic                                      host_ack_o,
  // Keyboard and reset control
  input  wire logic [2:0]                           key_row_sel_i,
  output logic      [7:0]                           key_line_o,
  output logic                                      cpu_reset_req_o,
  // External memory
  output logic                                      mem_valid_o,
  input  wire logic                                 mem_ready_i,
  output logic      [ti_sys_pkg::xaddr_w-1:0]       mem_addr_o,
  output logic                                      mem_we_o,
  output logic      [1:0]                           mem_be_o,
  output logic      [ti_sys_pkg::data_w-1:0]        mem_wdata_o,
  input  wire logic [ti_sys_pkg::data_w-1:0]        mem_rdata_i
);

  xmem_req_if cpu_req ();
  xmem_req_if host_req ();

  cpu_mem_map i_cpu_mem_map (
    .clk         (clk),
    .cpu_reset   (cpu_reset),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_rd_i    (cpu_rd_i),
    .cpu_wr_i    (cpu_wr_i),
    .cpu_wdata_i (cpu_wdata_i),
    .cpu_rdata_o (cpu_rdata_o),
    .cpu_ready_o (cpu_ready_o),
    .mem         (cpu_req.requester)
  );

  host_ctrl_port i_host_ctrl_port (
    .clk             (clk),
    .cpu_reset       (cpu_reset),
    .host_addr_i     (host_addr_i),
    .host_read_i     (host_read_i),
    .host_write_i    (host_write_i),
    .host_wdata_i    (host_wdata_i),
    .host_rdata_o    (host_rdata_o),
    .host_ack_o      (host_ack_o),
    .key_row_sel_i   (key_row_sel_i),
    .key_line_o      (key_line_o),
    .cpu_reset_req_o (cpu_reset_req_o),
    .mem             (host_req.requester)
  );

  xmem_arbiter i_xmem_arbiter (
    .cpu         (cpu_req.arbiter),
    .host        (host_req.arbiter),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_be_o    (mem_be_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: design/ti_sys_pkg.sv
/*
 * Shared constants and types for the TI-99/4A memory glue.
 * Holds the memory-map widths, the CPU region codes and the host address union.
 * Every design file refers to these by package-scoped names.
 */
`default_nettype none

package ti_sys_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int cpu_addr_w  = 16;
  localparam int xaddr_w     = 23;  // External memory word address
  localparam int data_w      = 16;
  localparam int page_w      = 8;   // Cartridge bank page
  localparam int host_addr_w = 32;
  localparam int kbd_rows    = 8;

  // Reset control after reset with bit 0 high so the CPU runs
  localparam logic [7:0] reset_ctrl_init = 8'hff;

  // Cartridge pages live at 1M words in external memory
  localparam logic [2:0] cart_base = 3'b001;

  // ------------------------------------------------------------
  // CPU address regions
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    rom,
    ram,
    cart,
    scratch,
    unmapped
  } region_e;

  // Host address word, seen as a memory byte address or a control register
  typedef union packed {
    struct packed {
      logic [6:0]         upper;
      logic               space;  // Low for memory space
      logic [xaddr_w-1:0] word;   // Word address in external memory
      logic               lane;   // 0 selects the high byte
    } mem_view;
    struct packed {
      logic [6:0]  upper;
      logic        space;         // High for control space
      logic [18:0] rsvd;
      logic [1:0]  group;         // 0 keyboard, 1 reset control
      logic [2:0]  row;
    } ctrl_view;
  } host_addr_u;

endpackage

`default_nettype wire

// File: design/xmem_arbiter.sv
/*
 * Fixed-priority merge of the host and CPU requests onto the single
 * external memory port. The host wins whenever it is valid.
 */
`timescale 1ns/1ps
`default_nettype none

module xmem_arbiter (
  xmem_req_if.arbiter                             cpu,
  xmem_req_if.arbiter                             host,
  output logic                                    mem_valid_o,
  input  wire logic                               mem_ready_i,
  output logic      [ti_sys_pkg::xaddr_w-1:0]     mem_addr_o,
  output logic                                    mem_we_o,
  output logic      [1:0]                         mem_be_o,
  output logic      [ti_sys_pkg::data_w-1:0]      mem_wdata_o,
  input  wire logic [ti_sys_pkg::data_w-1:0]      mem_rdata_i
);

  logic host_sel;

  // Host holds valid until its ack, so it keeps the port for the whole request
  assign host_sel = host.valid;

  assign mem_valid_o = host.valid || cpu.valid;
  assign mem_addr_o  = host_sel ? host.addr  : cpu.addr;
  assign mem_we_o    = host_sel ? host.we    : cpu.we;
  assign mem_be_o    = host_sel ? host.be    : cpu.be;
  assign mem_wdata_o = host_sel ? host.wdata : cpu.wdata;

  // ------------------------------------------------------------
  // Response routing, only the granted side sees ready and data
  // ------------------------------------------------------------
  assign host.ready = host_sel && mem_ready_i;
  assign cpu.ready  = !host_sel && mem_ready_i;
  assign host.rdata = host_sel ? mem_rdata_i : '0;
  assign cpu.rdata  = host_sel ? '0 : mem_rdata_i;

endmodule

`default_nettype wire

// File: design/xmem_req_if.sv
/*
 * Request channel to external memory with a valid/ready handshake.
 * Fields stay stable until the cycle with valid and ready both high,
 * read data is valid in that same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface xmem_req_if;

  logic                               valid;
  logic                               ready;
  logic [ti_sys_pkg::xaddr_w-1:0]     addr;
  logic                               we;
  logic [1:0]                         be;     // Upper, lower byte
  logic [ti_sys_pkg::data_w-1:0]      wdata;
  logic [ti_sys_pkg::data_w-1:0]      rdata;

  modport requester (
    output valid, addr, we, be, wdata,
    input  ready, rdata
  );

  modport arbiter (
    input  valid, addr, we, be, wdata,
    output ready, rdata
  );

endinterface

`default_nettype wire

// File: test/tb_ti_sys_core.sv
/*
 * Testbench for the TI-99/4A memory glue. Runs a table of CPU and host
 * transactions against a memory model with random back-pressure and checks
 * read data, memory port fields, keyboard lines and the CPU reset request.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ti_sys_core;

  localparam int          tmo_cycles  = 50;        // Per transaction
  localparam logic [15:0] mem_pattern = 16'hc3a5;

  typedef struct {
    string       name;
    bit          host;
    bit          wr;
    logic [31:0] addr;
    logic [15:0] wdata;
    logic [15:0] exp_rdata;
    logic [22:0] exp_maddr;
    logic [1:0]  exp_be;
    bit          exp_xfer;
    bit          pre_reset;      // Pulse cpu_reset before this entry
  } test_t;

  logic        clk = 1'b0;
  logic        cpu_reset;
  logic [15:0] cpu_addr;
  logic        cpu_rd;
  logic        cpu_wr;
  logic [15:0] cpu_wdata;
  logic [15:0] cpu_rdata;
  logic        cpu_ready;
  logic [31:0] host_addr;
  logic        host_read;
  logic        host_write;
  logic [7:0]  host_wdata;
  logic [7:0]  host_rdata;
  logic        host_ack;
  logic [2:0]  key_row_sel;
  logic [7:0]  key_line;
  logic        cpu_reset_req;
  logic        mem_valid;
  logic        mem_ready;
  logic [22:0] mem_addr;
  logic        mem_we;
  logic [1:0]  mem_be;
  logic [15:0] mem_wdata;
  logic [15:0] mem_rdata;

  test_t       tests[$];
  logic [22:0] xfer_log[$];      // Word address of every transfer in order
  logic [1:0]  last_be;
  logic        last_we;
  logic [15:0] last_wdata;
  logic [7:0]  kbd_exp [8];      // Keyboard rows the DUT should hold
  int          errors = 0;
  int          checks = 0;
  int unsigned sva_fails;
  bit          table_done = 1'b0;

  ti_sys_core i_ti_sys_core (
    .clk             (clk),
    .cpu_reset       (cpu_reset),
    .cpu_addr_i      (cpu_addr),
    .cpu_rd_i        (cpu_rd),
    .cpu_wr_i        (cpu_wr),
    .cpu_wdata_i     (cpu_wdata),
    .cpu_rdata_o     (cpu_rdata),
    .cpu_ready_o     (cpu_ready),
    .host_addr_i     (host_addr),
    .host_read_i     (host_read),
    .host_write_i    (host_write),
    .host_wdata_i    (host_wdata),
    .host_rdata_o    (host_rdata),
    .host_ack_o      (host_ack),
    .key_row_sel_i   (key_row_sel),
    .key_line_o      (key_line),
    .cpu_reset_req_o (cpu_reset_req),
    .mem_valid_o     (mem_valid),
    .mem_ready_i     (mem_ready),
    .mem_addr_o      (mem_addr),
    .mem_we_o        (mem_we),
    .mem_be_o        (mem_be),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata)
  );

  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // Expected values from the memory map rules
  // ------------------------------------------------------------
  function automatic logic [15:0] model_word(input logic [22:0] a);
    return a[15:0] ^ mem_pattern;
  endfunction

  function automatic logic [22:0] cpu_word(input logic [15:0] a);
    return {8'h00, a[15:1]};
  endfunction

  function automatic logic [22:0] cart_word(input logic [7:0] page, input logic [15:0] a);
    return {3'b001, page, a[12:1]};
  endfunction

  function automatic logic [31:0] ctrl_addr(input logic [1:0] group, input logic [2:0] row);
    ti_sys_pkg::host_addr_u a;
    a                 = '0;
    a.ctrl_view.space = 1'b1;
    a.ctrl_view.group = group;
    a.ctrl_view.row   = row;
    return a;
  endfunction

  function automatic logic [15:0] host_rd_exp(input logic [23:0] b);
    logic [15:0] w;
    w = model_word(b[23:1]);
    return b[0] ? {8'h00, w[7:0]} : {8'h00, w[15:8]};
  endfunction

  function automatic logic [1:0] host_lane(input logic [23:0] b);
    return b[0] ? 2'b01 : 2'b10;
  endfunction

  function automatic test_t make_test(input string name, input bit host, input bit wr,
      input logic [31:0] addr, input logic [15:0] wdata, input logic [15:0] exp_rdata,
      input logic [22:0] exp_maddr, input logic [1:0] exp_be, input bit exp_xfer,
      input bit pre_reset);
    test_t t;
    t.name      = name;
    t.host      = host;
    t.wr        = wr;
    t.addr      = addr;
    t.wdata     = wdata;
    t.exp_rdata = exp_rdata;
    t.exp_maddr = exp_maddr;
    t.exp_be    = exp_be;
    t.exp_xfer  = exp_xfer;
    t.pre_reset = pre_reset;
    return t;
  endfunction

  // ------------------------------------------------------------
  // Memory model with random ready and data derived from the address
  // ------------------------------------------------------------
  assign mem_rdata = model_word(mem_addr);

  initial begin
    void'($urandom(78810));
    mem_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      mem_ready = ($urandom_range(3, 0) != 0);
    end
  end

  always @(negedge clk) begin
    if (mem_valid && mem_ready) begin
      xfer_log.push_back(mem_addr);
      last_be    <= mem_be;
      last_we    <= mem_we;
      last_wdata <= mem_wdata;
    end
  end

  // ------------------------------------------------------------
  // Tasks
  // ------------------------------------------------------------
  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic apply_reset();
    cpu_reset = 1'b1;
    foreach (kbd_exp[i])
      kbd_exp[i] = 8'hff;  // All keys up
    repeat (2) @(posedge clk);
    #2;
    cpu_reset = 1'b0;
  endtask

  // Holds one request until its ready or ack and then releases it
  task automatic do_txn(input test_t t, output logic [15:0] rdata, output bit done);
    int cycles;
    cycles = 0;
    done   = 1'b0;
    if (t.host) begin
      host_addr  = t.addr;
      host_wdata = t.wdata[7:0];
      host_write = t.wr;
      host_read  = !t.wr;
    end else begin
      cpu_addr  = t.addr[15:0];
      cpu_wdata = t.wdata;
      cpu_wr    = t.wr;
      cpu_rd    = !t.wr;
    end
    while (!done && cycles < tmo_cycles) begin
      @(negedge clk);
      done = t.host ? host_ack : cpu_ready;
      cycles++;
    end
    rdata = t.host ? {8'h00, host_rdata} : cpu_rdata;
    @(posedge clk);
    #2;
    if (t.host) begin
      host_read  = 1'b0;
      host_write = 1'b0;
    end else begin
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
    end
    assert (done) else begin
      errors++;
      $display("%s: no response from the DUT within %0d cycles", t.name, tmo_cycles);
    end
  endtask

  task automatic run_entry(input test_t t);
    logic [15:0] rdata;
    logic [15:0] exp_wdata;
    bit          done;
    int          n0;
    if (t.pre_reset)
      apply_reset();
    n0        = xfer_log.size();
    exp_wdata = t.host ? {t.wdata[7:0], t.wdata[7:0]} : t.wdata;
    do_txn(t, rdata, done);
    if (done) begin
      if (!t.wr)
        expect_eq({t.name, " rdata"}, 32'(t.exp_rdata), 32'(rdata));
      expect_eq({t.name, " transfers"}, t.exp_xfer ? 32'd1 : 32'd0,
                32'(xfer_log.size() - n0));
      if (t.exp_xfer && xfer_log.size() > n0) begin
        expect_eq({t.name, " mem_addr"}, 32'(t.exp_maddr), 32'(xfer_log[n0]));
        expect_eq({t.name, " mem_be"}, 32'(t.exp_be), 32'(last_be));
        expect_eq({t.name, " mem_we"}, 32'(t.wr), 32'(last_we));
        if (t.wr)
          expect_eq({t.name, " mem_wdata"}, 32'(exp_wdata), 32'(last_wdata));
      end
      // Control-space writes show up on the keyboard line or the reset request
      if (t.host && t.wr && t.addr[24]) begin
        if (t.addr[4:3] == 2'd0) begin
          kbd_exp[t.addr[2:0]] = t.wdata[7:0];
          for (int r = 0; r < 8; r++) begin
            key_row_sel = 3'(r);
            @(negedge clk);
            expect_eq($sformatf("%s key_line row%0d", t.name, r), 32'(kbd_exp[r]),
                      32'(key_line));
            @(posedge clk);
            #2;
          end
        end else if (t.addr[4:3] == 2'd1) begin
          @(negedge clk);
          expect_eq({t.name, " reset_req"}, 32'(!t.wdata[0]), 32'(cpu_reset_req));
        end
      end
    end
    @(posedge clk);  // Idle cycle so the sticky ready can drop
    #2;
  endtask

  // Host and CPU raise requests in the same cycle and the host goes first
  task automatic run_contention();
    test_t       h;
    test_t       c;
    logic [15:0] h_data;
    logic [15:0] c_data;
    bit          h_done;
    bit          c_done;
    int          n0;
    h = make_test("contend_host", 1'b1, 1'b0, 32'h0000_0101, 16'h0000,
      host_rd_exp(24'h000101), 23'h000080, 2'b01, 1'b1, 1'b0);
    c = make_test("contend_cpu", 1'b0, 1'b0, 32'h0000_2468, 16'h0000,
      model_word(cpu_word(16'h2468)), cpu_word(16'h2468), 2'b11, 1'b1, 1'b0);
    n0 = xfer_log.size();
    fork
      do_txn(h, h_data, h_done);
      do_txn(c, c_data, c_done);
    join
    if (h_done && c_done) begin
      expect_eq("contend transfers", 32'd2, 32'(xfer_log.size() - n0));
      if (xfer_log.size() >= n0 + 2) begin
        expect_eq("contend first mem_addr", 32'(h.exp_maddr), 32'(xfer_log[n0]));
        expect_eq("contend second mem_addr", 32'(c.exp_maddr), 32'(xfer_log[n0 + 1]));
      end
      expect_eq("contend_host rdata", 32'(h.exp_rdata), 32'(h_data));
      expect_eq("contend_cpu rdata", 32'(c.exp_rdata), 32'(c_data));
    end
    @(posedge clk);
    #2;
  endtask

  task automatic build_table();
    logic [7:0] kbd [8];
    kbd = '{8'hfe, 8'hfd, 8'hfb, 8'hf7, 8'hef, 8'hdf, 8'hbf, 8'h7f};  // One key down per row
    tests.push_back(make_test("rom_rd", 1'b0, 1'b0, 32'h0000_0124, 16'h0000,
      model_word(cpu_word(16'h0124)), cpu_word(16'h0124), 2'b11, 1'b1, 1'b0));
    tests.push_back(make_test("ram_lo_rd", 1'b0, 1'b0, 32'h0000_2468, 16'h0000,
      model_word(cpu_word(16'h2468)), cpu_word(16'h2468), 2'b11, 1'b1, 1'b0));
    tests.push_back(make_test("scratch_rd", 1'b0, 1'b0, 32'h0000_8300, 16'h0000,
      model_word(cpu_word(16'h8300)), cpu_word(16'h8300), 2'b11, 1'b1, 1'b0));
    tests.push_back(make_test("ram_hi_rd", 1'b0, 1'b0, 32'h0000_c002, 16'h0000,
      model_word(cpu_word(16'hc002)), cpu_word(16'hc002), 2'b11, 1'b1, 1'b0));
    tests.push_back(make_test("unmapped_rd", 1'b0, 1'b0, 32'h0000_9000, 16'h0000,
      16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("rom_wr", 1'b0, 1'b1, 32'h0000_0040, 16'hdead,
      16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("ram_wr", 1'b0, 1'b1, 32'h0000_a010, 16'hbeef,
      16'h0000, cpu_word(16'ha010), 2'b11, 1'b1, 1'b0));
    tests.push_back(make_test("cart_page_wr", 1'b0, 1'b1, 32'h0000_600a, 16'h1234,
      16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("cart_rd", 1'b0, 1'b0, 32'h0000_6abc, 16'h0000,
      model_word(cart_word(8'h05, 16'h6abc)), cart_word(8'h05, 16'h6abc), 2'b11, 1'b1, 1'b0));
    for (int r = 0; r < 8; r++) begin
      tests.push_back(make_test($sformatf("kbd_wr_row%0d", r), 1'b1, 1'b1,
        ctrl_addr(2'd0, 3'(r)), {8'h00, kbd[r]}, 16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    end
    for (int r = 0; r < 8; r++) begin
      tests.push_back(make_test($sformatf("kbd_rd_row%0d", r), 1'b1, 1'b0,
        ctrl_addr(2'd0, 3'(r)), 16'h0000, {8'h00, kbd[r]}, 23'h0, 2'b00, 1'b0, 1'b0));
    end
    tests.push_back(make_test("rst_ctrl_wr_hold", 1'b1, 1'b1, ctrl_addr(2'd1, 3'd0), 16'h00a6,
      16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("rst_ctrl_rd_hold", 1'b1, 1'b0, ctrl_addr(2'd1, 3'd0), 16'h0000,
      16'h00a6, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("rst_ctrl_wr_run", 1'b1, 1'b1, ctrl_addr(2'd1, 3'd0), 16'h0035,
      16'h0000, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("rst_ctrl_rd_run", 1'b1, 1'b0, ctrl_addr(2'd1, 3'd0), 16'h0000,
      16'h0035, 23'h0, 2'b00, 1'b0, 1'b0));
    tests.push_back(make_test("host_wr_hi", 1'b1, 1'b1, 32'h0012_3456, 16'h005a,
      16'h0000, 23'h091a2b, host_lane(24'h123456), 1'b1, 1'b0));
    tests.push_back(make_test("host_wr_lo", 1'b1, 1'b1, 32'h0012_3457, 16'h00a7,
      16'h0000, 23'h091a2b, host_lane(24'h123457), 1'b1, 1'b0));
    tests.push_back(make_test("host_rd_hi", 1'b1, 1'b0, 32'h0000_0abc, 16'h0000,
      host_rd_exp(24'h000abc), 23'h00055e, host_lane(24'h000abc), 1'b1, 1'b0));
    tests.push_back(make_test("host_rd_lo", 1'b1, 1'b0, 32'h0000_0abd, 16'h0000,
      host_rd_exp(24'h000abd), 23'h00055e, host_lane(24'h000abd), 1'b1, 1'b0));
    tests.push_back(make_test("cart_rd_after_reset", 1'b0, 1'b0, 32'h0000_6abc, 16'h0000,
      model_word(cart_word(8'h00, 16'h6abc)), cart_word(8'h00, 16'h6abc), 2'b11, 1'b1, 1'b1));
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    cpu_addr    = 16'h0000;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_wdata   = 16'h0000;
    host_addr   = 32'h0000_0000;
    host_read   = 1'b0;
    host_write  = 1'b0;
    host_wdata  = 8'h00;
    key_row_sel = 3'd0;
    build_table();
    table_done = 1'b1;
    apply_reset();
    foreach (tests[i])
      run_entry(tests[i]);
    run_contention();
    sva_fails = i_ti_sys_core.i_ti_sys_core_sva.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (table_done);
    repeat (tests.size() * 60) @(posedge clk);
    $display("Timeout: the run did not end within %0d cycles", tests.size() * 60);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/ti_sys_core_sva.sv
/*
 * Protocol checks bound into the DUT top level. Covers the memory request
 * hold rule, the sticky CPU ready and the one-cycle host ack.
 */
`timescale 1ns/1ps
`default_nettype none

module ti_sys_core_sva (
  input wire logic                               clk,
  input wire logic                               cpu_reset,
  input wire logic                               mem_valid_o,
  input wire logic                               mem_ready_i,
  input wire logic [ti_sys_pkg::xaddr_w-1:0]     mem_addr_o,
  input wire logic                               mem_we_o,
  input wire logic [1:0]                         mem_be_o,
  input wire logic [ti_sys_pkg::data_w-1:0]      mem_wdata_o,
  input wire logic                               cpu_rd_i,
  input wire logic                               cpu_wr_i,
  input wire logic                               cpu_ready_o,
  input wire logic                               host_ack_o
);

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Request stays up with the same fields until memory accepts it
  mem_hold: assert property (@(posedge clk) disable iff (cpu_reset)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) && $stable(mem_we_o)
      && $stable(mem_be_o) && $stable(mem_wdata_o))
    else begin
      fail_count++;
      $error("memory request dropped or changed before mem_ready_i");
    end

  cpu_ready_sticky: assert property (@(posedge clk) disable iff (cpu_reset)
    cpu_ready_o && (cpu_rd_i || cpu_wr_i) |=> cpu_ready_o)
    else begin
      fail_count++;
      $error("cpu_ready_o fell while rd or wr was still high");
    end

  host_ack_pulse: assert property (@(posedge clk) disable iff (cpu_reset)
    host_ack_o |=> !host_ack_o)
    else begin
      fail_count++;
      $error("host_ack_o lasted more than one cycle");
    end

endmodule

bind ti_sys_core ti_sys_core_sva i_ti_sys_core_sva (
  .clk         (clk),
  .cpu_reset   (cpu_reset),
  .mem_valid_o (mem_valid_o),
  .mem_ready_i (mem_ready_i),
  .mem_addr_o  (mem_addr_o),
  .mem_we_o    (mem_we_o),
  .mem_be_o    (mem_be_o),
  .mem_wdata_o (mem_wdata_o),
  .cpu_rd_i    (cpu_rd_i),
  .cpu_wr_i    (cpu_wr_i),
  .cpu_ready_o (cpu_ready_o),
  .host_ack_o  (host_ack_o)
);

`default_nettype wire
